// ==== link_pkg.sv ====
`default_nettype none

package link_pkg;

  parameter int x_cord_width_gp = 4;
  parameter int y_cord_width_gp = 3;
  parameter int addr_width_gp   = 8;
  parameter int data_width_gp   = 16;

  // request packet, 31 bits
  typedef struct packed {
    logic [addr_width_gp-1:0]   addr;
    logic [data_width_gp-1:0]   data;
    logic [x_cord_width_gp-1:0] src_x;
    logic [y_cord_width_gp-1:0] src_y;
  } fwd_packet_s;

  // response packet, 23 bits
  typedef struct packed {
    logic [data_width_gp-1:0]   data;
    logic [x_cord_width_gp-1:0] dst_x;
    logic [y_cord_width_gp-1:0] dst_y;
  } rev_packet_s;

endpackage

`default_nettype wire

// ==== pod_row_sdr.f ====
link_pkg.sv
sdr_pkg.sv
tag_reset_client.sv
sdr_uplink.sv
sdr_downlink.sv
sdr_link_node.sv
pod_row_sdr.sv
tb_pod_row_sdr.sv

// ==== pod_row_sdr.sv ====
`timescale 1ns/1ns
`default_nettype none

module pod_row_sdr
  import link_pkg::*;
  import sdr_pkg::*;
  #(parameter int num_links_p = num_links_gd
    , parameter int lg_fifo_depth_p = lg_fifo_depth_gd
    , parameter int lg_credit_decimation_p = lg_credit_decimation_gd
    , parameter int reset_sync_stages_p = reset_sync_stages_gd
  )
  (input  logic core_clk_i
   , input  logic reset_i
   , input  logic tag_en_i
   , input  logic tag_data_i

   , input  logic [x_cord_width_gp-1:0] global_x_i [num_links_p]
   , input  logic [y_cord_width_gp-1:0] global_y_i [num_links_p]
   , output logic [x_cord_width_gp-1:0] core_x_o   [num_links_p]
   , output logic [y_cord_width_gp-1:0] core_y_o   [num_links_p]
   , output logic                       core_reset_o [num_links_p]

   , input  logic        fwd_v_i        [num_links_p]
   , input  fwd_packet_s fwd_data_i     [num_links_p]
   , output logic        fwd_ready_o    [num_links_p]
   , output logic        fwd_v_o        [num_links_p]
   , output fwd_packet_s fwd_data_o     [num_links_p]
   , input  logic        fwd_ready_i    [num_links_p]
   , output logic        io_fwd_v_o     [num_links_p]
   , output fwd_packet_s io_fwd_data_o  [num_links_p]
   , input  logic        io_fwd_token_i [num_links_p]
   , input  logic        io_fwd_v_i     [num_links_p]
   , input  fwd_packet_s io_fwd_data_i  [num_links_p]
   , output logic        io_fwd_token_o [num_links_p]

   , input  logic        rev_v_i        [num_links_p]
   , input  rev_packet_s rev_data_i     [num_links_p]
   , output logic        rev_ready_o    [num_links_p]
   , output logic        rev_v_o        [num_links_p]
   , output rev_packet_s rev_data_o     [num_links_p]
   , input  logic        rev_ready_i    [num_links_p]
   , output logic        io_rev_v_o     [num_links_p]
   , output rev_packet_s io_rev_data_o  [num_links_p]
   , input  logic        io_rev_token_i [num_links_p]
   , input  logic        io_rev_v_i     [num_links_p]
   , input  rev_packet_s io_rev_data_i  [num_links_p]
   , output logic        io_rev_token_o [num_links_p]
  );

  logic client_reset_lo;
  logic [num_links_p-1:0] node_reset_li;

  tag_reset_client #(
    .reset_sync_stages_p (reset_sync_stages_p)
  ) tag_client (
    .core_clk_i    (core_clk_i)
    ,.reset_i      (reset_i)
    ,.tag_en_i     (tag_en_i)
    ,.tag_data_i   (tag_data_i)
    ,.core_reset_o (client_reset_lo)
  );

  for (genvar i = 0; i < num_links_p; i++) begin : link
    // reset hops from node to node
    if (i == 0) begin : head
      assign node_reset_li[i] = client_reset_lo;
    end else begin : chain
      assign node_reset_li[i] = core_reset_o[i-1];
    end

    sdr_link_node #(
      .lg_fifo_depth_p         (lg_fifo_depth_p)
      ,.lg_credit_decimation_p (lg_credit_decimation_p)
    ) node (
      .core_clk_i      (core_clk_i)
      ,.reset_i        (reset_i)
      ,.core_reset_i   (node_reset_li[i])
      ,.core_reset_o   (core_reset_o[i])
      ,.global_x_i     (global_x_i[i])
      ,.global_y_i     (global_y_i[i])
      ,.core_x_o       (core_x_o[i])
      ,.core_y_o       (core_y_o[i])

      ,.fwd_v_i        (fwd_v_i[i])
      ,.fwd_data_i     (fwd_data_i[i])
      ,.fwd_ready_o    (fwd_ready_o[i])
      ,.fwd_v_o        (fwd_v_o[i])
      ,.fwd_data_o     (fwd_data_o[i])
      ,.fwd_ready_i    (fwd_ready_i[i])
      ,.io_fwd_v_o     (io_fwd_v_o[i])
      ,.io_fwd_data_o  (io_fwd_data_o[i])
      ,.io_fwd_token_i (io_fwd_token_i[i])
      ,.io_fwd_v_i     (io_fwd_v_i[i])
      ,.io_fwd_data_i  (io_fwd_data_i[i])
      ,.io_fwd_token_o (io_fwd_token_o[i])

      ,.rev_v_i        (rev_v_i[i])
      ,.rev_data_i     (rev_data_i[i])
      ,.rev_ready_o    (rev_ready_o[i])
      ,.rev_v_o        (rev_v_o[i])
      ,.rev_data_o     (rev_data_o[i])
      ,.rev_ready_i    (rev_ready_i[i])
      ,.io_rev_v_o     (io_rev_v_o[i])
      ,.io_rev_data_o  (io_rev_data_o[i])
      ,.io_rev_token_i (io_rev_token_i[i])
      ,.io_rev_v_i     (io_rev_v_i[i])
      ,.io_rev_data_i  (io_rev_data_i[i])
      ,.io_rev_token_o (io_rev_token_o[i])
    );
  end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
rm -f sim.log
verilator --binary --timing --top-module tb_pod_row_sdr -f pod_row_sdr.f -o sim_pod_row_sdr \
  > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_pod_row_sdr > sim.log 2>&1 || true
cat sim.log
grep -q "Verification failed" sim.log && exit 1
grep -q "Verification passed" sim.log && exit 0 || exit 1

// ==== sdr_downlink.sv ====
`timescale 1ns/1ns
`default_nettype none

module sdr_downlink
  import sdr_pkg::*;
  #(parameter type payload_t = logic
    , parameter int lg_fifo_depth_p = lg_fifo_depth_gd
    , parameter int lg_credit_decimation_p = lg_credit_decimation_gd
  )
  (input  logic     core_clk_i
   , input  logic     reset_i
   , input  logic     io_v_i
   , input  payload_t io_data_i
   , output logic     io_token_o
   , output logic     v_o
   , output payload_t data_o
   , input  logic     ready_i
  );

  localparam int depth_lp = 2**lg_fifo_depth_p;
  localparam int ptr_width_lp = lg_fifo_depth_p + 1;
  localparam int cnt_width_lp = (lg_credit_decimation_p > 0) ? lg_credit_decimation_p : 1;
  localparam logic [cnt_width_lp-1:0] cnt_last_lp =
    cnt_width_lp'(2**lg_credit_decimation_p - 1);

  payload_t mem_r [depth_lp];
  logic [ptr_width_lp-1:0] wr_ptr_r;
  logic [ptr_width_lp-1:0] rd_ptr_r;
  logic [cnt_width_lp-1:0] drain_cnt_r;
  logic token_r;
  logic deq;

  // sender credits keep this from overflowing
  always_ff @(posedge core_clk_i) begin
    if (io_v_i) begin
      mem_r[wr_ptr_r[lg_fifo_depth_p-1:0]] <= io_data_i;
    end
  end

  assign v_o    = (wr_ptr_r != rd_ptr_r);
  assign data_o = mem_r[rd_ptr_r[lg_fifo_depth_p-1:0]];
  assign deq    = v_o & ready_i;

  always_ff @(posedge core_clk_i) begin
    if (reset_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
    end else begin
      if (io_v_i) begin
        wr_ptr_r <= wr_ptr_r + ptr_width_lp'(1);
      end
      if (deq) begin
        rd_ptr_r <= rd_ptr_r + ptr_width_lp'(1);
      end
    end
  end

  // one token per full batch drained
  always_ff @(posedge core_clk_i) begin
    if (reset_i) begin
      drain_cnt_r <= '0;
      token_r     <= 1'b0;
    end else begin
      token_r <= deq & (drain_cnt_r == cnt_last_lp);
      if (deq) begin
        if (drain_cnt_r == cnt_last_lp) begin
          drain_cnt_r <= '0;
        end else begin
          drain_cnt_r <= drain_cnt_r + cnt_width_lp'(1);
        end
      end
    end
  end

  assign io_token_o = token_r;

endmodule

`default_nettype wire

// ==== sdr_link_node.sv ====
`timescale 1ns/1ns
`default_nettype none

module sdr_link_node
  import link_pkg::*;
  import sdr_pkg::*;
  #(parameter int lg_fifo_depth_p = lg_fifo_depth_gd
    , parameter int lg_credit_decimation_p = lg_credit_decimation_gd
  )
  (input  logic core_clk_i
   , input  logic reset_i

   , input  logic core_reset_i
   , output logic core_reset_o

   , input  logic [x_cord_width_gp-1:0] global_x_i
   , input  logic [y_cord_width_gp-1:0] global_y_i
   , output logic [x_cord_width_gp-1:0] core_x_o
   , output logic [y_cord_width_gp-1:0] core_y_o

   // forward, core side
   , input  logic        fwd_v_i
   , input  fwd_packet_s fwd_data_i
   , output logic        fwd_ready_o
   , output logic        fwd_v_o
   , output fwd_packet_s fwd_data_o
   , input  logic        fwd_ready_i

   // forward, io side
   , output logic        io_fwd_v_o
   , output fwd_packet_s io_fwd_data_o
   , input  logic        io_fwd_token_i
   , input  logic        io_fwd_v_i
   , input  fwd_packet_s io_fwd_data_i
   , output logic        io_fwd_token_o

   // reverse, core side
   , input  logic        rev_v_i
   , input  rev_packet_s rev_data_i
   , output logic        rev_ready_o
   , output logic        rev_v_o
   , output rev_packet_s rev_data_o
   , input  logic        rev_ready_i

   // reverse, io side
   , output logic        io_rev_v_o
   , output rev_packet_s io_rev_data_o
   , input  logic        io_rev_token_i
   , input  logic        io_rev_v_i
   , input  rev_packet_s io_rev_data_i
   , output logic        io_rev_token_o
  );

  // one register stage per node on the reset chain
  always_ff @(posedge core_clk_i) begin
    if (reset_i) begin
      core_reset_o <= 1'b1;
      core_x_o     <= '0;
      core_y_o     <= '0;
    end else begin
      core_reset_o <= core_reset_i;
      core_x_o     <= global_x_i;
      core_y_o     <= global_y_i;
    end
  end

  sdr_uplink #(
    .payload_t               (fwd_packet_s)
    ,.lg_fifo_depth_p        (lg_fifo_depth_p)
    ,.lg_credit_decimation_p (lg_credit_decimation_p)
  ) fwd_up (
    .core_clk_i   (core_clk_i)
    ,.reset_i     (reset_i)
    ,.v_i         (fwd_v_i)
    ,.data_i      (fwd_data_i)
    ,.ready_o     (fwd_ready_o)
    ,.io_v_o      (io_fwd_v_o)
    ,.io_data_o   (io_fwd_data_o)
    ,.io_token_i  (io_fwd_token_i)
  );

  sdr_downlink #(
    .payload_t               (fwd_packet_s)
    ,.lg_fifo_depth_p        (lg_fifo_depth_p)
    ,.lg_credit_decimation_p (lg_credit_decimation_p)
  ) fwd_down (
    .core_clk_i   (core_clk_i)
    ,.reset_i     (reset_i)
    ,.io_v_i      (io_fwd_v_i)
    ,.io_data_i   (io_fwd_data_i)
    ,.io_token_o  (io_fwd_token_o)
    ,.v_o         (fwd_v_o)
    ,.data_o      (fwd_data_o)
    ,.ready_i     (fwd_ready_i)
  );

  sdr_uplink #(
    .payload_t               (rev_packet_s)
    ,.lg_fifo_depth_p        (lg_fifo_depth_p)
    ,.lg_credit_decimation_p (lg_credit_decimation_p)
  ) rev_up (
    .core_clk_i   (core_clk_i)
    ,.reset_i     (reset_i)
    ,.v_i         (rev_v_i)
    ,.data_i      (rev_data_i)
    ,.ready_o     (rev_ready_o)
    ,.io_v_o      (io_rev_v_o)
    ,.io_data_o   (io_rev_data_o)
    ,.io_token_i  (io_rev_token_i)
  );

  sdr_downlink #(
    .payload_t               (rev_packet_s)
    ,.lg_fifo_depth_p        (lg_fifo_depth_p)
    ,.lg_credit_decimation_p (lg_credit_decimation_p)
  ) rev_down (
    .core_clk_i   (core_clk_i)
    ,.reset_i     (reset_i)
    ,.io_v_i      (io_rev_v_i)
    ,.io_data_i   (io_rev_data_i)
    ,.io_token_o  (io_rev_token_o)
    ,.v_o         (rev_v_o)
    ,.data_o      (rev_data_o)
    ,.ready_i     (rev_ready_i)
  );

endmodule

`default_nettype wire

// ==== sdr_pkg.sv ====
`default_nettype none

package sdr_pkg;

  parameter int num_links_gd            = 3;
  // depth 4
  parameter int lg_fifo_depth_gd        = 2;
  // two packets per token
  parameter int lg_credit_decimation_gd = 1;
  parameter int reset_sync_stages_gd    = 2;

endpackage

`default_nettype wire

// ==== sdr_uplink.sv ====
`timescale 1ns/1ns
`default_nettype none

module sdr_uplink
  import sdr_pkg::*;
  #(parameter type payload_t = logic
    , parameter int lg_fifo_depth_p = lg_fifo_depth_gd
    , parameter int lg_credit_decimation_p = lg_credit_decimation_gd
  )
  (input  logic     core_clk_i
   , input  logic     reset_i
   , input  logic     v_i
   , input  payload_t data_i
   , output logic     ready_o
   , output logic     io_v_o
   , output payload_t io_data_o
   , input  logic     io_token_i
  );

  localparam int depth_lp = 2**lg_fifo_depth_p;
  localparam int ptr_width_lp = lg_fifo_depth_p + 1;
  localparam int credit_width_lp = ((lg_fifo_depth_p > lg_credit_decimation_p)
    ? lg_fifo_depth_p : lg_credit_decimation_p) + 1;
  localparam logic [credit_width_lp-1:0] credit_init_lp = credit_width_lp'(depth_lp);
  localparam logic [credit_width_lp-1:0] token_credits_lp =
    credit_width_lp'(2**lg_credit_decimation_p);

  payload_t mem_r [depth_lp];
  logic [ptr_width_lp-1:0] wr_ptr_r;
  logic [ptr_width_lp-1:0] rd_ptr_r;
  logic [credit_width_lp-1:0] credit_r;
  logic empty;
  logic full;
  logic enq;
  logic deq;

  assign empty = (wr_ptr_r == rd_ptr_r);
  // same slot, writer one lap ahead
  assign full = (wr_ptr_r[lg_fifo_depth_p] != rd_ptr_r[lg_fifo_depth_p])
    && (wr_ptr_r[lg_fifo_depth_p-1:0] == rd_ptr_r[lg_fifo_depth_p-1:0]);

  assign ready_o = ~full;
  assign enq = v_i & ~full;
  // send only with data and credit
  assign deq = ~empty & (credit_r != '0);

  assign io_v_o    = deq;
  assign io_data_o = mem_r[rd_ptr_r[lg_fifo_depth_p-1:0]];

  always_ff @(posedge core_clk_i) begin
    if (enq) begin
      mem_r[wr_ptr_r[lg_fifo_depth_p-1:0]] <= data_i;
    end
  end

  always_ff @(posedge core_clk_i) begin
    if (reset_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
    end else begin
      if (enq) begin
        wr_ptr_r <= wr_ptr_r + ptr_width_lp'(1);
      end
      if (deq) begin
        rd_ptr_r <= rd_ptr_r + ptr_width_lp'(1);
      end
    end
  end

  // a token returns a whole batch of credits
  always_ff @(posedge core_clk_i) begin
    if (reset_i) begin
      credit_r <= credit_init_lp;
    end else begin
      case ({io_token_i, deq})
        2'b10:   credit_r <= credit_r + token_credits_lp;
        2'b01:   credit_r <= credit_r - credit_width_lp'(1);
        2'b11:   credit_r <= credit_r + token_credits_lp - credit_width_lp'(1);
        default: credit_r <= credit_r;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== tag_reset_client.sv ====
`timescale 1ns/1ns
`default_nettype none

module tag_reset_client
  import sdr_pkg::*;
  #(parameter int reset_sync_stages_p = reset_sync_stages_gd)
  (input  logic core_clk_i
   , input  logic reset_i
   , input  logic tag_en_i
   , input  logic tag_data_i
   , output logic core_reset_o
  );

  typedef enum logic {e_wait_start, e_take_data} tag_state_e;

  tag_state_e state_r;
  logic data_r;
  logic new_r;
  logic reset_word_r;
  logic [reset_sync_stages_p-1:0] sync_r;

  // start bit, then one data bit
  always_ff @(posedge core_clk_i) begin
    if (reset_i) begin
      state_r <= e_wait_start;
      new_r   <= 1'b0;
    end else begin
      new_r <= 1'b0;
      if (!tag_en_i) begin
        state_r <= e_wait_start;
      end else if (state_r == e_wait_start) begin
        if (tag_data_i) begin
          state_r <= e_take_data;
        end
      end else begin
        state_r <= e_wait_start;
        new_r   <= 1'b1;
      end
    end
  end

  always_ff @(posedge core_clk_i) begin
    if (tag_en_i && (state_r == e_take_data)) begin
      data_r <= tag_data_i;
    end
  end

  // cores held in reset until a word arrives
  always_ff @(posedge core_clk_i) begin
    if (reset_i) begin
      reset_word_r <= 1'b1;
    end else if (new_r) begin
      reset_word_r <= data_r;
    end
  end

  always_ff @(posedge core_clk_i) begin
    if (reset_i) begin
      sync_r <= '1;
    end else begin
      sync_r[0] <= reset_word_r;
      for (int i = 1; i < reset_sync_stages_p; i++) begin
        sync_r[i] <= sync_r[i-1];
      end
    end
  end

  assign core_reset_o = sync_r[reset_sync_stages_p-1];

endmodule

`default_nettype wire

// ==== tb_pod_row_sdr.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_pod_row_sdr
  import link_pkg::*;
  import sdr_pkg::*;
  ();

  localparam int n_lp           = num_links_gd;
  localparam int lg_depth_lp    = lg_fifo_depth_gd;
  localparam int lg_decim_lp    = lg_credit_decimation_gd;
  localparam int sync_stages_lp = reset_sync_stages_gd;
  localparam int depth_lp       = 2**lg_depth_lp;
  localparam int fwd_bits_lp    = $bits(fwd_packet_s);
  localparam int rev_bits_lp    = $bits(rev_packet_s);
  localparam int xy_bits_lp     = x_cord_width_gp + y_cord_width_gp;

  // test lengths in cycles
  localparam int settle_cycles_lp  = 20;
  localparam int chain_cycles_lp   = 40;
  localparam int credit_cycles_lp  = 24;
  localparam int drain_cycles_lp   = 24;
  localparam int traffic_cycles_lp = 1500;
  localparam int flush_cycles_lp   = 300;
  localparam int timeout_lp = 2 * (2 * settle_cycles_lp + chain_cycles_lp + credit_cycles_lp
    + drain_cycles_lp + traffic_cycles_lp + flush_cycles_lp);

  logic core_clk_i;
  logic reset_i;
  logic tag_en_i;
  logic tag_data_i;
  logic tokens_on;
  logic [x_cord_width_gp-1:0] global_x_i [n_lp];
  logic [y_cord_width_gp-1:0] global_y_i [n_lp];
  logic [x_cord_width_gp-1:0] core_x_o   [n_lp];
  logic [y_cord_width_gp-1:0] core_y_o   [n_lp];
  logic                       core_reset_o [n_lp];

  logic        fwd_v_i        [n_lp];
  fwd_packet_s fwd_data_i     [n_lp];
  logic        fwd_ready_o    [n_lp];
  logic        fwd_v_o        [n_lp];
  fwd_packet_s fwd_data_o     [n_lp];
  logic        fwd_ready_i    [n_lp];
  logic        io_fwd_v_o     [n_lp];
  fwd_packet_s io_fwd_data_o  [n_lp];
  logic        io_fwd_token_i [n_lp];
  logic        io_fwd_v_i     [n_lp];
  fwd_packet_s io_fwd_data_i  [n_lp];
  logic        io_fwd_token_o [n_lp];

  logic        rev_v_i        [n_lp];
  rev_packet_s rev_data_i     [n_lp];
  logic        rev_ready_o    [n_lp];
  logic        rev_v_o        [n_lp];
  rev_packet_s rev_data_o     [n_lp];
  logic        rev_ready_i    [n_lp];
  logic        io_rev_v_o     [n_lp];
  rev_packet_s io_rev_data_o  [n_lp];
  logic        io_rev_token_i [n_lp];
  logic        io_rev_v_i     [n_lp];
  rev_packet_s io_rev_data_i  [n_lp];
  logic        io_rev_token_o [n_lp];

  fwd_packet_s fwd_sb [n_lp][$];
  rev_packet_s rev_sb [n_lp][$];
  int fwd_sent [n_lp];
  int rev_sent [n_lp];
  int fwd_tokens [n_lp];
  int rev_tokens [n_lp];
  int fwd_drained [n_lp];
  int rev_drained [n_lp];
  logic [x_cord_width_gp-1:0] last_x [n_lp];
  logic [y_cord_width_gp-1:0] last_y [n_lp];
  logic coord_valid;
  logic [31:0] lfsr_r = 32'hbe75_1cef;
  int cycle_cnt = 0;

  pod_row_sdr #(
    .num_links_p             (n_lp)
    ,.lg_fifo_depth_p        (lg_depth_lp)
    ,.lg_credit_decimation_p (lg_decim_lp)
    ,.reset_sync_stages_p    (sync_stages_lp)
  ) DUT (.*);

  // each node talks to itself over io
  for (genvar k = 0; k < n_lp; k++) begin : loopback
    assign io_fwd_v_i[k]     = io_fwd_v_o[k];
    assign io_fwd_data_i[k]  = io_fwd_data_o[k];
    assign io_fwd_token_i[k] = tokens_on & io_fwd_token_o[k];
    assign io_rev_v_i[k]     = io_rev_v_o[k];
    assign io_rev_data_i[k]  = io_rev_data_o[k];
    assign io_rev_token_i[k] = tokens_on & io_rev_token_o[k];
  end

  initial core_clk_i = 1'b0;
  always #10 core_clk_i = ~core_clk_i;

  always @(posedge core_clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= timeout_lp) begin
      $display("Timeout: the run did not finish within %0d cycles", timeout_lp);
      $display("Verification failed");
      $fatal(1);
    end
  end

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_r[31] ^ lfsr_r[21] ^ lfsr_r[1] ^ lfsr_r[0];
      lfsr_r = {lfsr_r[30:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic logic queues_empty();
    logic e;
    e = 1'b1;
    for (int k = 0; k < n_lp; k++) begin
      if (fwd_sb[k].size() != 0 || rev_sb[k].size() != 0) begin
        e = 1'b0;
      end
    end
    return e;
  endfunction

  task automatic report_error(input string msg);
    $display("Error at %0t ns: %s", $time, msg);
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic idle_inputs();
    tag_en_i   = 1'b0;
    tag_data_i = 1'b0;
    for (int k = 0; k < n_lp; k++) begin
      fwd_v_i[k]     = 1'b0;
      rev_v_i[k]     = 1'b0;
      fwd_ready_i[k] = 1'b0;
      rev_ready_i[k] = 1'b0;
      fwd_data_i[k]  = '0;
      rev_data_i[k]  = '0;
      global_x_i[k]  = '0;
      global_y_i[k]  = '0;
    end
  endtask

  task automatic clear_counts();
    for (int k = 0; k < n_lp; k++) begin
      fwd_sb[k].delete();
      rev_sb[k].delete();
      fwd_sent[k]    = 0;
      rev_sent[k]    = 0;
      fwd_tokens[k]  = 0;
      rev_tokens[k]  = 0;
      fwd_drained[k] = 0;
      rev_drained[k] = 0;
    end
  endtask

  task automatic apply_reset();
    reset_i     = 1'b1;
    tokens_on   = 1'b0;
    coord_valid = 1'b0;
    idle_inputs();
    clear_counts();
    repeat (2) @(negedge core_clk_i);
    reset_i = 1'b0;
  endtask

  task automatic check_reset_values();
    for (int k = 0; k < n_lp; k++) begin
      assert (!io_fwd_v_o[k] && !io_rev_v_o[k] && !io_fwd_token_o[k] && !io_rev_token_o[k])
        else report_error($sformatf("node %0d io strobe or token high after reset", k));
      assert (!fwd_v_o[k] && !rev_v_o[k])
        else report_error($sformatf("node %0d core valid high after reset", k));
      assert (core_reset_o[k])
        else report_error($sformatf("node %0d core reset low after reset", k));
    end
  endtask

  // outputs seen at the falling edge, before new inputs go out
  task automatic observe_outputs();
    for (int k = 0; k < n_lp; k++) begin
      if (coord_valid) begin
        assert (core_x_o[k] == last_x[k] && core_y_o[k] == last_y[k])
          else report_error($sformatf("node %0d coordinate %h/%h, expected %h/%h",
            k, core_x_o[k], core_y_o[k], last_x[k], last_y[k]));
      end
      // a token follows a pop, and a pop needs ready
      assert (!io_fwd_token_o[k] || fwd_ready_i[k])
        else report_error($sformatf("node %0d fwd token with ready low", k));
      assert (!io_rev_token_o[k] || rev_ready_i[k])
        else report_error($sformatf("node %0d rev token with ready low", k));
      if (io_fwd_v_o[k]) fwd_sent[k]++;
      if (io_rev_v_o[k]) rev_sent[k]++;
      if (io_fwd_token_o[k]) fwd_tokens[k]++;
      if (io_rev_token_o[k]) rev_tokens[k]++;
      if (!tokens_on) begin
        assert (fwd_sent[k] <= depth_lp && rev_sent[k] <= depth_lp)
          else report_error($sformatf("node %0d uplink sent %0d/%0d with %0d credits",
            k, fwd_sent[k], rev_sent[k], depth_lp));
      end
    end
  endtask

  // handshakes that the next rising edge will take
  task automatic track_transfers();
    fwd_packet_s fwd_exp;
    rev_packet_s rev_exp;
    for (int k = 0; k < n_lp; k++) begin
      if (fwd_v_i[k] && fwd_ready_o[k]) fwd_sb[k].push_back(fwd_data_i[k]);
      if (rev_v_i[k] && rev_ready_o[k]) rev_sb[k].push_back(rev_data_i[k]);
      if (fwd_v_o[k] && fwd_ready_i[k]) begin
        assert (fwd_sb[k].size() > 0)
          else report_error($sformatf("node %0d fwd packet with none outstanding", k));
        fwd_exp = fwd_sb[k].pop_front();
        assert (fwd_data_o[k] == fwd_exp)
          else report_error($sformatf("node %0d fwd packet %h, expected %h",
            k, fwd_data_o[k], fwd_exp));
        fwd_drained[k]++;
      end
      if (rev_v_o[k] && rev_ready_i[k]) begin
        assert (rev_sb[k].size() > 0)
          else report_error($sformatf("node %0d rev packet with none outstanding", k));
        rev_exp = rev_sb[k].pop_front();
        assert (rev_data_o[k] == rev_exp)
          else report_error($sformatf("node %0d rev packet %h, expected %h",
            k, rev_data_o[k], rev_exp));
        rev_drained[k]++;
      end
    end
  endtask

  task automatic run_cycle(input logic random_on, input logic v_hold, input logic ready_hold);
    logic [31:0] r;
    @(negedge core_clk_i);
    observe_outputs();
    for (int k = 0; k < n_lp; k++) begin
      r = rand_bits(xy_bits_lp);
      global_x_i[k] = r[xy_bits_lp-1:y_cord_width_gp];
      global_y_i[k] = r[y_cord_width_gp-1:0];
      last_x[k] = global_x_i[k];
      last_y[k] = global_y_i[k];
      r = rand_bits(fwd_bits_lp);
      fwd_data_i[k] = r[fwd_bits_lp-1:0];
      r = rand_bits(rev_bits_lp);
      rev_data_i[k] = r[rev_bits_lp-1:0];
      if (random_on) begin
        r = rand_bits(4);
        fwd_v_i[k]     = r[0];
        rev_v_i[k]     = r[1];
        fwd_ready_i[k] = r[2];
        rev_ready_i[k] = r[3];
      end else begin
        fwd_v_i[k]     = v_hold;
        rev_v_i[k]     = v_hold;
        fwd_ready_i[k] = ready_hold;
        rev_ready_i[k] = ready_hold;
      end
    end
    coord_valid = 1'b1;
    track_transfers();
  endtask

  initial begin
    logic exp_reset;
    apply_reset();
    run_cycle(1'b0, 1'b0, 1'b0);
    check_reset_values();

    // tag word 0 releases the cores
    repeat (settle_cycles_lp) run_cycle(1'b0, 1'b0, 1'b0);
    tag_en_i   = 1'b1;
    tag_data_i = 1'b1;
    run_cycle(1'b0, 1'b0, 1'b0);
    tag_data_i = 1'b0;
    run_cycle(1'b0, 1'b0, 1'b0);
    tag_en_i = 1'b0;
    for (int c = 1; c <= sync_stages_lp + 2 + n_lp; c++) begin
      run_cycle(1'b0, 1'b0, 1'b0);
      for (int k = 0; k < n_lp; k++) begin
        exp_reset = (c < sync_stages_lp + 2 + k);
        assert (core_reset_o[k] == exp_reset)
          else report_error($sformatf("node %0d core reset %0b, expected %0b, %0d cycles on",
            k, core_reset_o[k], exp_reset, c));
      end
    end

    // no tokens back, core not draining
    repeat (credit_cycles_lp) run_cycle(1'b0, 1'b1, 1'b0);
    for (int k = 0; k < n_lp; k++) begin
      assert (fwd_sent[k] == depth_lp && rev_sent[k] == depth_lp)
        else report_error($sformatf("node %0d uplinks sent %0d/%0d, expected %0d",
          k, fwd_sent[k], rev_sent[k], depth_lp));
      assert (!fwd_ready_o[k] && !rev_ready_o[k])
        else report_error($sformatf("node %0d uplink ready with a full FIFO", k));
    end

    repeat (drain_cycles_lp) run_cycle(1'b0, 1'b0, 1'b1);
    for (int k = 0; k < n_lp; k++) begin
      assert (fwd_drained[k] == depth_lp && rev_drained[k] == depth_lp)
        else report_error($sformatf("node %0d drained %0d/%0d, expected %0d",
          k, fwd_drained[k], rev_drained[k], depth_lp));
      assert (fwd_tokens[k] == (fwd_drained[k] >> lg_decim_lp)
        && rev_tokens[k] == (rev_drained[k] >> lg_decim_lp))
        else report_error($sformatf("node %0d tokens %0d/%0d after a drain",
          k, fwd_tokens[k], rev_tokens[k]));
    end

    // random traffic on both directions with tokens looped back
    apply_reset();
    tokens_on = 1'b1;
    repeat (traffic_cycles_lp) run_cycle(1'b1, 1'b0, 1'b0);
    while (!queues_empty()) begin
      run_cycle(1'b0, 1'b0, 1'b1);
    end
    repeat (4) run_cycle(1'b0, 1'b0, 1'b1);
    for (int k = 0; k < n_lp; k++) begin
      assert (fwd_drained[k] > 0 && rev_drained[k] > 0)
        else report_error($sformatf("node %0d carried no traffic", k));
      assert (fwd_tokens[k] == (fwd_drained[k] >> lg_decim_lp)
        && rev_tokens[k] == (rev_drained[k] >> lg_decim_lp))
        else report_error($sformatf("node %0d tokens %0d/%0d for %0d/%0d drained",
          k, fwd_tokens[k], rev_tokens[k], fwd_drained[k], rev_drained[k]));
    end

    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire
